// File: build.f
+incdir+hdl
hdl/glay_resp_pkg.sv
hdl/response_fifo.sv
hdl/response_router.sv
hdl/lane_accumulator.sv
hdl/result_collector.sv
hdl/glay_response_top.sv
test/tb_glay_response.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the response subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -Wno-fatal -f build.f \
  --top-module tb_glay_response \
  || { echo "build error"; exit 1; }

out="$(./obj_dir/Vtb_glay_response)"
echo "$out"
echo "$out" | grep -qx "all tests passed" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// File: test/tb_glay_response.sv
// Testbench for glay_response_top
// Expected sums are built from the beats sent and kept in one queue per lane
// Stimulus holds off while prog_full is high, as the upstream source must
// Concurrent assertions do all checking and count into err_cnt
`timescale 1ns/1ps
`include "glay_resp_cfg.svh"

module tb_glay_response import glay_resp_pkg::*; ();

  logic           ap_clk = 1'b0;
  logic           areset_control;
  resp_packet_t   response_in;
  logic           prog_full;
  result_packet_t result_out;
  logic           result_ready;

  integer     seed = 19304;
  // Scoreboard, expected sum and beat count per vertex
  data_word_t exp_q [`GLAY_NUM_LANES][$];
  int         len_q [`GLAY_NUM_LANES][$];
  // Vertices still open in the interleaved test
  int         open_left [`GLAY_NUM_LANES];
  int         open_len [`GLAY_NUM_LANES];
  data_word_t open_acc [`GLAY_NUM_LANES];
  int         beats_sent = 0;
  int         beats_done = 0;
  int         results_seen = 0;
  int         err_cnt = 0;
  int         err_mark = 0;
  int         cycle_cnt = 0;
  int         test_num = 0;
  int         tests_ok = 0;
  logic       rst_q = 1'b1;
  logic       chk_valid = 1'b0;
  logic       chk_empty = 1'b0;
  lane_id_t   chk_lane;
  data_word_t chk_got;
  data_word_t chk_exp;
  logic       pf_check = 1'b0;
  logic       pf_hit = 1'b0;

  glay_response_top i_dut (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .response_in    (response_in),
    .prog_full      (prog_full),
    .result_out     (result_out),
    .result_ready   (result_ready)
  );

  always #10 ap_clk = ~ap_clk;

  // ----------------------------------------
  // Result monitor
  // ----------------------------------------
  // Accepted result captured with its scoreboard head, checked next cycle
  always @(posedge ap_clk) begin
    rst_q     <= areset_control;
    chk_valid <= 1'b0;
    if (!areset_control && result_out.valid && result_ready) begin
      chk_valid <= 1'b1;
      chk_lane  <= result_out.result.lane;
      chk_got   <= result_out.result.sum;
      results_seen++;
      if (exp_q[result_out.result.lane].size() == 0) begin
        chk_empty <= 1'b1;
      end else begin
        chk_empty  <= 1'b0;
        chk_exp    <= exp_q[result_out.result.lane].pop_front();
        beats_done += len_q[result_out.result.lane].pop_front();
      end
    end
  end

  // Run limit grows with the traffic sent
  always @(posedge ap_clk) begin
    cycle_cnt++;
    if (cycle_cnt > beats_sent * 8 + 200) begin
      $display("timeout at cycle %0d, %0d results never arrived", cycle_cnt, queued_results());
      $display("tests failed");
      $finish;
    end
  end

  // ----------------------------------------
  // Checks
  // ----------------------------------------
  a_reset_valid: assert property (@(posedge ap_clk)
    (rst_q && !areset_control) |-> !result_out.valid)
    else begin
      $display("ERR %0t result_out.valid got %b expected 0", $time, $sampled(result_out.valid));
      err_cnt++;
    end
  a_reset_pf: assert property (@(posedge ap_clk)
    (rst_q && !areset_control) |-> !prog_full)
    else begin
      $display("ERR %0t prog_full got %b expected 0", $time, $sampled(prog_full));
      err_cnt++;
    end
  // Sum and order per lane
  a_sum_match: assert property (@(posedge ap_clk)
    (chk_valid && !chk_empty) |-> (chk_got == chk_exp))
    else begin
      $display("ERR %0t result_out.result.sum lane %0d got %h expected %h",
               $time, chk_lane, chk_got, chk_exp);
      err_cnt++;
    end
  a_no_extra: assert property (@(posedge ap_clk) chk_valid |-> !chk_empty)
    else begin
      $display("result on lane %0d arrived with no sum outstanding", chk_lane);
      err_cnt++;
    end
  // FIFO fill never exceeds the beats still owed a result
  a_pf_level: assert property (@(posedge ap_clk)
    prog_full |-> ((beats_sent - beats_done) >= `GLAY_PROG_THRESH))
    else begin
      $display("prog_full high with only %0d beats pending", beats_sent - beats_done);
      err_cnt++;
    end
  a_pf_rise: assert property (@(posedge ap_clk) pf_check |-> pf_hit)
    else begin
      $display("prog_full never rose while result_ready was held low");
      err_cnt++;
    end

  // ----------------------------------------
  // Stimulus helpers
  // ----------------------------------------
  function automatic int queued_results();
    int n;
    n = 0;
    for (int l = 0; l < `GLAY_NUM_LANES; l++) begin
      n += exp_q[l].size();
    end
    return n;
  endfunction

  task automatic expect_sum(input lane_id_t lane, input data_word_t sum, input int len);
    exp_q[lane].push_back(sum);
    len_q[lane].push_back(len);
  endtask

  // Drive in the current cycle, no wait
  task automatic drive_beat(input lane_id_t lane, input logic last, input data_word_t data);
    response_in <= '{valid: 1'b1, payload: '{lane: lane, last: last, data: data}};
    beats_sent++;
  endtask

  // Next edge, holding off while prog_full is high
  task automatic send_beat(input lane_id_t lane, input logic last, input data_word_t data);
    @(posedge ap_clk);
    while (prog_full) begin
      response_in.valid <= 1'b0;
      @(posedge ap_clk);
    end
    drive_beat(lane, last, data);
  endtask

  task automatic send_vertex(input lane_id_t lane, input int len);
    data_word_t sum;
    data_word_t data;
    sum = '0;
    for (int b = 0; b < len; b++) begin
      data = $random(seed);
      sum  = sum + data;
      send_beat(lane, b == len - 1, data);
    end
    expect_sum(lane, sum, len);
  endtask

  // One beat on a lane, opening a vertex of 1 to 6 beats if none is open
  task automatic mixed_beat(input lane_id_t ln);
    data_word_t data;
    if (open_left[ln] == 0) begin
      open_left[ln] = 1 + int'($unsigned($random(seed)) % 6);
      open_len[ln]  = open_left[ln];
      open_acc[ln]  = '0;
    end
    data          = $random(seed);
    open_acc[ln]  = open_acc[ln] + data;
    open_left[ln] = open_left[ln] - 1;
    send_beat(ln, open_left[ln] == 0, data);
    if (open_left[ln] == 0) begin
      expect_sum(ln, open_acc[ln], open_len[ln]);
    end
  endtask

  task automatic mixed_vertices(input int steps);
    for (int s = 0; s < steps; s++) begin
      mixed_beat(lane_id_t'($random(seed)));
    end
    // Close what is still open
    for (int l = 0; l < `GLAY_NUM_LANES; l++) begin
      while (open_left[l] != 0) begin
        mixed_beat(lane_id_t'(l));
      end
    end
  endtask

  // Single beats until prog_full shows, with a cap
  task automatic fill_until_prog_full();
    lane_id_t   ln;
    data_word_t data;
    for (int n = 0; n < 30; n++) begin
      @(posedge ap_clk);
      if (prog_full) begin
        response_in.valid <= 1'b0;
        break;
      end
      ln   = lane_id_t'($random(seed));
      data = $random(seed);
      drive_beat(ln, 1'b1, data);
      expect_sum(ln, data, 1);
    end
    pf_hit   <= prog_full;
    pf_check <= 1'b1;
    @(posedge ap_clk);
    pf_check          <= 1'b0;
    response_in.valid <= 1'b0;
  endtask

  // Stop input and wait for every expected sum
  task automatic drain(input logic random_ready);
    @(posedge ap_clk);
    response_in.valid <= 1'b0;
    while (queued_results() != 0) begin
      if (random_ready) begin
        result_ready <= 1'($random(seed));
      end else begin
        result_ready <= 1'b1;
      end
      @(posedge ap_clk);
    end
    result_ready <= 1'b1;
    repeat (4) @(posedge ap_clk);
  endtask

  task automatic end_test(input string name);
    test_num++;
    if (err_cnt == err_mark) begin
      tests_ok++;
      $display("test %0d %s: ok", test_num, name);
    end else begin
      $display("test %0d %s: %0d errors", test_num, name, err_cnt - err_mark);
    end
    err_mark = err_cnt;
  endtask

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin
    for (int l = 0; l < `GLAY_NUM_LANES; l++) begin
      open_left[l] = 0;
    end
    areset_control <= 1'b1;
    response_in    <= '0;
    result_ready   <= 1'b1;
    repeat (16) @(posedge ap_clk);
    areset_control <= 1'b0;

    repeat (4) @(posedge ap_clk);
    end_test("idle after reset");

    for (int l = 0; l < `GLAY_NUM_LANES; l++) begin
      send_vertex(lane_id_t'(l), 1);
    end
    drain(1'b0);
    end_test("single beat per lane");

    mixed_vertices(40);
    drain(1'b0);
    end_test("interleaved multi-beat vertices");

    // Output stalled until the FIFO reports prog_full
    @(posedge ap_clk);
    result_ready <= 1'b0;
    fill_until_prog_full();
    drain(1'b0);
    end_test("back-pressure to prog_full");

    @(posedge ap_clk);
    result_ready <= 1'b0;
    for (int l = 0; l < `GLAY_NUM_LANES; l++) begin
      send_vertex(lane_id_t'(l), 1 + int'($unsigned($random(seed)) % 3));
    end
    // Second vertex per lane queues behind the held results
    for (int l = 0; l < `GLAY_NUM_LANES; l++) begin
      send_vertex(lane_id_t'(l), 1);
    end
    @(posedge ap_clk);
    response_in.valid <= 1'b0;
    repeat (12) @(posedge ap_clk);
    drain(1'b1);
    end_test("random result_ready drain");

    $display("summary: %0d of %0d tests ok, %0d results checked, %0d errors",
             tests_ok, test_num, results_seen, err_cnt);
    if (err_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: hdl/glay_response_top.sv
// Response side of the overlay, router to lanes to collector
// Upstream must honour prog_full, there is no input ready
// Lane count fixed by GLAY_NUM_LANES
`timescale 1ns/1ps
`include "glay_resp_cfg.svh"

module glay_response_top import glay_resp_pkg::*; (
  input  logic           ap_clk,
  input  logic           areset_control,
  input  resp_packet_t   response_in,
  output logic           prog_full,
  output result_packet_t result_out,
  input  logic           result_ready
);

  resp_packet_t               lane_pkt [`GLAY_NUM_LANES];
  logic [`GLAY_NUM_LANES-1:0] lane_ready;
  logic [`GLAY_NUM_LANES-1:0] req;
  logic [`GLAY_NUM_LANES-1:0] ack;
  lane_result_t               lane_result [`GLAY_NUM_LANES];

  // ----------------------------------------
  // Input side
  // ----------------------------------------
  response_router i_router (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .response_in    (response_in),
    .lane_ready     (lane_ready),
    .lane_pkt       (lane_pkt),
    .prog_full      (prog_full)
  );

  // One accumulator per lane
  for (genvar i = 0; i < `GLAY_NUM_LANES; i++) begin : g_lane
    lane_accumulator i_lane (
      .ap_clk         (ap_clk),
      .areset_control (areset_control),
      .lane_pkt       (lane_pkt[i]),
      .lane_ready     (lane_ready[i]),
      .req            (req[i]),
      .ack            (ack[i]),
      .result         (lane_result[i])
    );
  end

  // Output side
  result_collector i_collector (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .req            (req),
    .result_in      (lane_result),
    .ack            (ack),
    .result_out     (result_out),
    .result_ready   (result_ready)
  );

endmodule

// File: hdl/result_collector.sv
// Round-robin receiver of lane results over four-phase req/ack
// Drives one valid/ready result port from an output register
// Acks nobody while the output register is full and not taken
`timescale 1ns/1ps
`include "glay_resp_cfg.svh"

module result_collector import glay_resp_pkg::*; (
  input  logic                       ap_clk,
  input  logic                       areset_control,
  input  logic [`GLAY_NUM_LANES-1:0] req,
  input  lane_result_t               result_in [`GLAY_NUM_LANES],
  output logic [`GLAY_NUM_LANES-1:0] ack,
  output result_packet_t             result_out,
  input  logic                       result_ready
);

  col_state_t   state;
  lane_id_t     last_grant;
  lane_id_t     pick;
  logic         found;
  logic         out_free;
  logic         grant;
  logic         out_valid_q;
  lane_result_t out_res_q;

  // ----------------------------------------
  // Round-robin pick
  // ----------------------------------------
  // First requester after the last grant
  always_comb begin
    found = 1'b0;
    pick  = last_grant;
    for (int k = 1; k <= `GLAY_NUM_LANES; k++) begin
      if (!found && req[(int'(last_grant) + k) % `GLAY_NUM_LANES]) begin
        found = 1'b1;
        pick  = lane_id_t'((int'(last_grant) + k) % `GLAY_NUM_LANES);
      end
    end
  end

  // Output register empty or drained this cycle
  assign out_free = !out_valid_q || result_ready;
  assign grant    = (state == SCAN) && found && out_free;

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      state      <= SCAN;
      ack        <= '0;
      // Lane 0 goes first
      last_grant <= lane_id_t'(`GLAY_NUM_LANES - 1);
    end else begin
      case (state)
        SCAN: if (grant) begin
          ack[pick]  <= 1'b1;
          last_grant <= pick;
          state      <= ACK;
        end
        ACK:     if (!req[last_grant]) state <= RELEASE;
        RELEASE: begin
          ack   <= '0;
          state <= SCAN;
        end
        default: state <= SCAN;
      endcase
    end
  end

  // ----------------------------------------
  // Output register
  // ----------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      out_valid_q <= 1'b0;
    end else if (grant) begin
      out_valid_q <= 1'b1;
    end else if (result_ready) begin
      out_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (grant) begin
      out_res_q <= result_in[pick];
    end
  end

  assign result_out = {out_valid_q, out_res_q};

  a_one_ack: assert property (@(posedge ap_clk) disable iff (areset_control)
    $onehot0(ack));
  // A lane keeps req up until it sees its ack
  a_req_held: assert property (@(posedge ap_clk) disable iff (areset_control)
    ($past(req) & ~$past(ack) & ~req) == '0);

endmodule

// File: hdl/lane_accumulator.sv
// Sums the data words of one vertex until its last beat
// Offers the sum to the collector with a four-phase req/ack
// Takes no beat until the handshake has completed
`timescale 1ns/1ps

module lane_accumulator import glay_resp_pkg::*; (
  input  logic         ap_clk,
  input  logic         areset_control,
  input  resp_packet_t lane_pkt,
  output logic         lane_ready,
  output logic         req,
  input  logic         ack,
  output lane_result_t result
);

  hs_state_t  state;
  data_word_t sum;
  logic       last_beat;

  assign last_beat = lane_pkt.valid && lane_pkt.payload.last;

  // ----------------------------------------
  // Running sum
  // ----------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      sum <= '0;
    end else if (last_beat) begin
      // Next vertex starts from zero
      sum <= '0;
    end else if (lane_pkt.valid) begin
      sum <= sum + lane_pkt.payload.data;
    end
  end

  // Final sum includes the last beat itself
  // Lane id taken from the beat
  always_ff @(posedge ap_clk) begin
    if (last_beat) begin
      result <= '{lane: lane_pkt.payload.lane, sum: sum + lane_pkt.payload.data};
    end
  end

  // ----------------------------------------
  // Four-phase handshake
  // ----------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE:      if (last_beat) state <= REQ;
        REQ:       if (ack) state <= WAIT_DROP;
        // Wait for the collector to release ack
        WAIT_DROP: if (!ack) state <= IDLE;
        default:   state <= IDLE;
      endcase
    end
  end

  assign req        = (state == REQ);
  assign lane_ready = (state == IDLE);

  // Result held while offered
  a_result_stable: assert property (@(posedge ap_clk) disable iff (areset_control)
    req |=> (!req || $stable(result)));
  // Router respects lane_ready
  a_no_beat_busy: assert property (@(posedge ap_clk) disable iff (areset_control)
    lane_pkt.valid |-> lane_ready);

endmodule

// File: hdl/response_router.sv
// Registers memory responses, buffers them and routes the head beat to its lane
// Upstream has no ready and must stop while prog_full is high
// The head blocks until its lane is ready, other lanes wait behind it
`timescale 1ns/1ps
`include "glay_resp_cfg.svh"

module response_router import glay_resp_pkg::*; (
  input  logic                       ap_clk,
  input  logic                       areset_control,
  input  resp_packet_t               response_in,
  input  logic [`GLAY_NUM_LANES-1:0] lane_ready,
  output resp_packet_t               lane_pkt [`GLAY_NUM_LANES],
  output logic                       prog_full
);

  logic                       in_valid_q;
  resp_payload_t              in_payload_q;
  resp_payload_t              fifo_head;
  logic                       fifo_rd;
  logic                       fifo_empty;
  logic                       head_ok;
  logic [`GLAY_NUM_LANES-1:0] pkt_valid;
  resp_payload_t              pkt_payload;

  // ----------------------------------------
  // Input register
  // ----------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      in_valid_q <= 1'b0;
    end else begin
      in_valid_q <= response_in.valid;
    end
  end

  always_ff @(posedge ap_clk) begin
    in_payload_q <= response_in.payload;
  end

  // Push on the registered valid
  response_fifo i_fifo (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .din            (in_payload_q),
    .wr_en          (in_valid_q),
    .rd_en          (fifo_rd),
    .dout           (fifo_head),
    .dout_valid     (),
    .full           (),
    .empty          (fifo_empty),
    .prog_full      (prog_full)
  );

  // ----------------------------------------
  // Pop and lane decode
  // ----------------------------------------
  // Target lane ready and no beat to it leaving this cycle
  assign head_ok = lane_ready[fifo_head.lane] && !pkt_valid[fifo_head.lane];
  assign fifo_rd = !fifo_empty && head_ok;

  // One registered valid per lane
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      pkt_valid <= '0;
    end else begin
      for (int i = 0; i < `GLAY_NUM_LANES; i++) begin
        pkt_valid[i] <= fifo_rd && (fifo_head.lane == lane_id_t'(i));
      end
    end
  end

  // Popped beat, held until the next pop
  always_ff @(posedge ap_clk) begin
    if (fifo_rd) begin
      pkt_payload <= fifo_head;
    end
  end

  // Payload fans out to every lane
  always_comb begin
    for (int i = 0; i < `GLAY_NUM_LANES; i++) begin
      lane_pkt[i] = {pkt_valid[i], pkt_payload};
    end
  end

  // Blocked head keeps its value until popped
  a_head_hold: assert property (@(posedge ap_clk) disable iff (areset_control)
    (!fifo_empty && !fifo_rd) |=> $stable(fifo_head));

endmodule

// File: hdl/response_fifo.sv
// Synchronous register FIFO, depth a power of two
// dout always shows the head entry, registered
// dout_valid is high the cycle after a pop
// Writing while full or reading while empty is illegal
`timescale 1ns/1ps
`include "glay_resp_cfg.svh"

module response_fifo import glay_resp_pkg::*; (
  input  logic          ap_clk,
  input  logic          areset_control,
  input  resp_payload_t din,
  input  logic          wr_en,
  input  logic          rd_en,
  output resp_payload_t dout,
  output logic          dout_valid,
  output logic          full,
  output logic          empty,
  output logic          prog_full
);

  localparam int PTR_W = $clog2(`GLAY_FIFO_DEPTH);
  localparam int CNT_W = $clog2(`GLAY_FIFO_DEPTH + 1);

  resp_payload_t    mem [`GLAY_FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] rd_ptr_nxt;
  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] count_nxt;

  // Pointer and fill level after this cycle
  assign rd_ptr_nxt = rd_en ? rd_ptr + 1'b1 : rd_ptr;
  assign count_nxt  = count + CNT_W'(wr_en) - CNT_W'(rd_en);

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      dout_valid <= 1'b0;
      prog_full  <= 1'b0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      rd_ptr     <= rd_ptr_nxt;
      count      <= count_nxt;
      dout_valid <= rd_en;
      // Registered from the next fill level
      prog_full  <= (count_nxt >= CNT_W'(`GLAY_PROG_THRESH));
    end
  end

  // Storage
  always_ff @(posedge ap_clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= din;
    end
  end

  // Head register, write-through when the new beat becomes the head
  always_ff @(posedge ap_clk) begin
    if (wr_en && (wr_ptr == rd_ptr_nxt)) begin
      dout <= din;
    end else begin
      dout <= mem[rd_ptr_nxt];
    end
  end

  assign full  = (count == CNT_W'(`GLAY_FIFO_DEPTH));
  assign empty = (count == '0);

  a_no_write_full: assert property (@(posedge ap_clk) disable iff (areset_control)
    wr_en |-> !full);
  a_no_read_empty: assert property (@(posedge ap_clk) disable iff (areset_control)
    rd_en |-> !empty);

endmodule

// File: hdl/glay_resp_pkg.sv
// Types shared by the response subsystem
// Widths come from the cfg header
`include "glay_resp_cfg.svh"

package glay_resp_pkg;

  // ----------------------------------------
  // Plain vectors
  // ----------------------------------------
  // Destination lane of a beat
  typedef logic [`GLAY_LANE_W-1:0] lane_id_t;
  // Data word, also used for sums
  typedef logic [`GLAY_DATA_W-1:0] data_word_t;

  // ----------------------------------------
  // Packets
  // ----------------------------------------
  // One response beat, 35 bits with the default sizes
  typedef struct packed {
    lane_id_t   lane;
    logic       last;
    data_word_t data;
  } resp_payload_t;

  typedef struct packed {
    logic          valid;
    resp_payload_t payload;
  } resp_packet_t;

  // Finished vertex sum, tagged with its lane
  typedef struct packed {
    lane_id_t   lane;
    data_word_t sum;
  } lane_result_t;

  typedef struct packed {
    logic         valid;
    lane_result_t result;
  } result_packet_t;

  // ----------------------------------------
  // State machines
  // ----------------------------------------
  // Lane side of the four-phase handshake
  typedef enum logic [1:0] {IDLE, REQ, WAIT_DROP} hs_state_t;
  // Collector side
  typedef enum logic [1:0] {SCAN, ACK, RELEASE} col_state_t;

endpackage

// File: hdl/glay_resp_cfg.svh
// Sizes for the response subsystem
// GLAY_LANE_W must cover GLAY_NUM_LANES
// GLAY_FIFO_DEPTH must be a power of two
// GLAY_PROG_THRESH leaves room for the input register and upstream reaction
`ifndef GLAY_RESP_CFG_SVH
`define GLAY_RESP_CFG_SVH

// ----------------------------------------
// Lanes
// ----------------------------------------
`define GLAY_NUM_LANES 4
`define GLAY_LANE_W 2

// Data word and sum width
`define GLAY_DATA_W 32

// ----------------------------------------
// Response FIFO
// ----------------------------------------
`define GLAY_FIFO_DEPTH 16
`define GLAY_PROG_THRESH 12

`endif
